// ==== verilog/cpuPkg.sv ====
// shared widths, encodings and the pipeline control word for the pipelined MIPS core
// referenced by scoped names from every stage and the testbench
package cpuPkg;

	// machine word and register file geometry
	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;
	localparam int regCount = 32;

	// primary opcode field, instr[31:26]
	typedef enum logic [5:0] {
		opRtype = 6'h00,
		opAddi = 6'h08,
		opLw = 6'h23,
		opSw = 6'h2b
	} opcodeT;

	// R-type function field, instr[5:0]
	typedef enum logic [5:0] {
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnOr = 6'h25,
		fnSlt = 6'h2a
	} functT;

	typedef enum logic [2:0] {
		aluAdd = 3'd0,
		aluSub = 3'd1,
		aluAnd = 3'd2,
		aluOr = 3'd3,
		aluSlt = 3'd4
	} aluOpT;

	// coarse ALU class from main control, refined in EX by the funct field
	typedef enum logic [1:0] {
		classMem = 2'b00,
		classImm = 2'b01,
		classFunct = 2'b10
	} aluClassT;

	// operand source picked by the forwarding unit
	typedef enum logic [1:0] {
		fwdNone = 2'b00,
		fwdExMem = 2'b01,
		fwdMemWb = 2'b10
	} fwdSelT;

	// control word travelling ID -> EX -> MEM -> WB, all zero is a bubble
	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic memRead;
		logic memWrite;
		logic aluSrc;
		logic regDst;
		aluClassT aluClass;
	} ctrlT;

endpackage

// ==== verilog/pipeBus.sv ====
// stage-to-stage bundles of the pipelined core
// exMemBus is the EX/MEM register, wbBus the writeback port of the register file
interface exMemBus;

	// EX/MEM register contents
	cpuPkg::ctrlT ctrl;
	logic [cpuPkg::dataWidth-1:0] aluResult;
	logic [cpuPkg::dataWidth-1:0] storeData;
	logic [cpuPkg::regAddrWidth-1:0] destReg;

	// execute stage owns the register
	modport producer (
		output ctrl, aluResult, storeData, destReg
	);

	// memory stage
	modport consumer (
		input ctrl, aluResult, storeData, destReg
	);

	// forwarding path back into EX, store data not needed there
	modport forwardSrc (
		input ctrl, aluResult, destReg
	);

endinterface

interface wbBus;

	// wbWrite is only ever set for a non-zero destination
	logic wbWrite;
	logic [cpuPkg::regAddrWidth-1:0] wbReg;
	logic [cpuPkg::dataWidth-1:0] wbData;

	modport source (
		output wbWrite, wbReg, wbData
	);

	// register file write port in decode
	modport regWriter (
		input wbWrite, wbReg, wbData
	);

	// MEM/WB forwarding into EX
	modport forwardSrc (
		input wbWrite, wbReg, wbData
	);

endinterface

// ==== verilog/fetchStage.sv ====
// instruction fetch: word PC, instruction memory with a program load port, IF/ID register
// programs are written through progWrite while rstN is held low
module fetchStage #(
	parameter int imemWords = 64
) (
	input logic clk,
	input logic rstN,
	input logic stall,
	input logic progWrite,
	input logic [$clog2(imemWords)-1:0] progAddr,
	input logic [cpuPkg::dataWidth-1:0] progData,
	output logic [cpuPkg::dataWidth-1:0] ifIdInstr
);

	localparam int pcWidth = $clog2(imemWords);

	// pc counts words, not bytes
	logic [pcWidth-1:0] pc;
	logic [cpuPkg::dataWidth-1:0] imem [imemWords];

	// unwritten words read as zero, which decodes as a nop to r0
	initial begin
		for (int i = 0; i < imemWords; i++) begin
			imem[i] = '0;
		end
	end

	// load port, independent of the pipeline
	always_ff @(posedge clk) begin
		if (progWrite) begin
			imem[progAddr] <= progData;
		end
	end

	// pc and IF/ID both freeze on a load-use stall
	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= '0;
			ifIdInstr <= '0;
		end else if (!stall) begin
			pc <= pc + 1'b1;
			ifIdInstr <= imem[pc];
		end
	end

	// the program may only change while the core is held in reset
	progLoadInReset: assert property (@(posedge clk) progWrite |-> !rstN)
		else $error("instruction memory written while the core is running");

endmodule

// ==== verilog/decodeStage.sv ====
// instruction decode: main control, register file with WB bypass, load-use hazard check
// and the ID/EX register feeding the execute stage
module decodeStage (
	input logic clk,
	input logic rstN,
	input logic [cpuPkg::dataWidth-1:0] ifIdInstr,
	wbBus.regWriter wb,
	output logic stall,
	output cpuPkg::ctrlT idExCtrl,
	output logic [cpuPkg::dataWidth-1:0] idExRs1Data,
	output logic [cpuPkg::dataWidth-1:0] idExRs2Data,
	output logic [cpuPkg::dataWidth-1:0] idExImm,
	output logic [cpuPkg::regAddrWidth-1:0] idExRs,
	output logic [cpuPkg::regAddrWidth-1:0] idExRt,
	output logic [cpuPkg::regAddrWidth-1:0] idExRd,
	output cpuPkg::functT idExFunct
);

	cpuPkg::opcodeT opcode;
	cpuPkg::ctrlT ctrl;
	logic [cpuPkg::regAddrWidth-1:0] rs;
	logic [cpuPkg::regAddrWidth-1:0] rt;
	logic [cpuPkg::regAddrWidth-1:0] rd;
	logic [cpuPkg::dataWidth-1:0] rs1Data;
	logic [cpuPkg::dataWidth-1:0] rs2Data;
	logic [cpuPkg::dataWidth-1:0] imm;
	logic [cpuPkg::dataWidth-1:0] regs [cpuPkg::regCount];

	// instruction fields
	assign opcode = cpuPkg::opcodeT'(ifIdInstr[31:26]);
	assign rs = ifIdInstr[25:21];
	assign rt = ifIdInstr[20:16];
	assign rd = ifIdInstr[15:11];
	assign imm = {{(cpuPkg::dataWidth-16){ifIdInstr[15]}}, ifIdInstr[15:0]};

	// main control, unknown opcodes turn into bubbles
	always_comb begin
		ctrl = '0;
		case (opcode)
			cpuPkg::opRtype: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst = 1'b1;
				ctrl.aluClass = cpuPkg::classFunct;
			end
			cpuPkg::opAddi: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluClass = cpuPkg::classImm;
			end
			cpuPkg::opLw: begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluClass = cpuPkg::classMem;
			end
			cpuPkg::opSw: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluClass = cpuPkg::classMem;
			end
			default: ;
		endcase
	end

	// register file write in WB, r0 stays unwritten
	always_ff @(posedge clk) begin
		if (wb.wbWrite && wb.wbReg != '0) begin
			regs[wb.wbReg] <= wb.wbData;
		end
	end

	// read port: r0 is hardwired zero, a same-cycle WB write wins over the array
	function automatic logic [cpuPkg::dataWidth-1:0] readReg(
		input logic [cpuPkg::regAddrWidth-1:0] idx,
		input logic wrEn,
		input logic [cpuPkg::regAddrWidth-1:0] wrIdx,
		input logic [cpuPkg::dataWidth-1:0] wrData
	);
		if (idx == '0) begin
			return '0;
		end else if (wrEn && wrIdx == idx) begin
			return wrData;
		end
		return regs[idx];
	endfunction

	always_comb begin
		rs1Data = readReg(rs, wb.wbWrite, wb.wbReg, wb.wbData);
		rs2Data = readReg(rt, wb.wbWrite, wb.wbReg, wb.wbData);
	end

	// load in EX whose target is a source of the instruction in ID
	assign stall = idExCtrl.memRead && (idExRt == rs || idExRt == rt);

	// ID/EX, a stall leaves a bubble behind the load
	always_ff @(posedge clk) begin
		if (!rstN || stall) begin
			idExCtrl <= '0;
		end else begin
			idExCtrl <= ctrl;
		end
		idExRs1Data <= rs1Data;
		idExRs2Data <= rs2Data;
		idExImm <= imm;
		idExRs <= rs;
		idExRt <= rt;
		idExRd <= rd;
		idExFunct <= cpuPkg::functT'(ifIdInstr[5:0])
		;
	end

	// a stall freezes the instruction in IF/ID for exactly one cycle
	stallSingleCycle: assert property (@(posedge clk) disable iff (!rstN)
		stall |=> !stall && $stable(ifIdInstr))
		else $error("load-use stall held for two cycles or IF/ID not frozen");

endmodule

// ==== verilog/executeStage.sv ====
// execute: forwarding unit and operand muxes, ALU control, ALU and the EX/MEM register
// EX/MEM has priority over MEM/WB when both hold the same destination
module executeStage (
	input logic clk,
	input logic rstN,
	input cpuPkg::ctrlT idExCtrl,
	input logic [cpuPkg::dataWidth-1:0] idExRs1Data,
	input logic [cpuPkg::dataWidth-1:0] idExRs2Data,
	input logic [cpuPkg::dataWidth-1:0] idExImm,
	input logic [cpuPkg::regAddrWidth-1:0] idExRs,
	input logic [cpuPkg::regAddrWidth-1:0] idExRt,
	input logic [cpuPkg::regAddrWidth-1:0] idExRd,
	input cpuPkg::functT idExFunct,
	exMemBus.producer exMem,
	exMemBus.forwardSrc exMemFwd,
	wbBus.forwardSrc wb
);

	cpuPkg::fwdSelT fwdA;
	cpuPkg::fwdSelT fwdB;
	cpuPkg::aluOpT aluOp;
	logic [cpuPkg::dataWidth-1:0] opA;
	logic [cpuPkg::dataWidth-1:0] rtValue;
	logic [cpuPkg::dataWidth-1:0] opB;
	logic [cpuPkg::dataWidth-1:0] aluResult;
	logic [cpuPkg::regAddrWidth-1:0] destReg;

	// a source qualifies only with regWrite set and a non-zero destination
	function automatic cpuPkg::fwdSelT pickFwd(
		input logic [cpuPkg::regAddrWidth-1:0] src,
		input logic exWrite,
		input logic [cpuPkg::regAddrWidth-1:0] exDest,
		input logic wbWrite,
		input logic [cpuPkg::regAddrWidth-1:0] wbDest
	);
		if (exWrite && exDest != '0 && exDest == src) begin
			return cpuPkg::fwdExMem;
		end else if (wbWrite && wbDest != '0 && wbDest == src) begin
			return cpuPkg::fwdMemWb;
		end
		return cpuPkg::fwdNone;
	endfunction

	function automatic logic [cpuPkg::dataWidth-1:0] fwdMux(
		input cpuPkg::fwdSelT sel,
		input logic [cpuPkg::dataWidth-1:0] regVal,
		input logic [cpuPkg::dataWidth-1:0] exVal,
		input logic [cpuPkg::dataWidth-1:0] wbVal
	);
		case (sel)
			cpuPkg::fwdExMem: return exVal;
			cpuPkg::fwdMemWb: return wbVal;
			default: return regVal;
		endcase
	endfunction

	always_comb begin
		fwdA = pickFwd(idExRs, exMemFwd.ctrl.regWrite, exMemFwd.destReg, wb.wbWrite, wb.wbReg);
		fwdB = pickFwd(idExRt, exMemFwd.ctrl.regWrite, exMemFwd.destReg, wb.wbWrite, wb.wbReg);
		opA = fwdMux(fwdA, idExRs1Data, exMemFwd.aluResult, wb.wbData);
		rtValue = fwdMux(fwdB, idExRs2Data, exMemFwd.aluResult, wb.wbData);
	end

	// immediate for addi, lw and sw; rt value also becomes the store data
	assign opB = idExCtrl.aluSrc ? idExImm : rtValue;

	// ALU control, loads, stores and addi all add
	always_comb begin
		aluOp = cpuPkg::aluAdd;
		if (idExCtrl.aluClass == cpuPkg::classFunct) begin
			case (idExFunct)
				cpuPkg::fnSub: aluOp = cpuPkg::aluSub;
				cpuPkg::fnAnd: aluOp = cpuPkg::aluAnd;
				cpuPkg::fnOr: aluOp = cpuPkg::aluOr;
				cpuPkg::fnSlt: aluOp = cpuPkg::aluSlt;
				default: aluOp = cpuPkg::aluAdd;
			endcase
		end
	end

	always_comb begin
		case (aluOp)
			cpuPkg::aluSub: aluResult = opA - opB;
			cpuPkg::aluAnd: aluResult = opA & opB;
			cpuPkg::aluOr: aluResult = opA | opB;
			// signed compare
			cpuPkg::aluSlt: aluResult = {{(cpuPkg::dataWidth-1){1'b0}}, $signed(opA) < $signed(opB)};
			default: aluResult = opA + opB;
		endcase
	end

	assign destReg = idExCtrl.regDst ? idExRd : idExRt;

	// EX/MEM register
	always_ff @(posedge clk) begin
		if (!rstN) begin
			exMem.ctrl <= '0;
		end else begin
			exMem.ctrl <= idExCtrl;
		end
		exMem.aluResult <= aluResult;
		exMem.storeData <= rtValue;
		exMem.destReg <= destReg;
	end

	// a real instruction takes an EX/MEM forward only from a writer that is not a load,
	// since the load-use stall keeps load data out of this path
	fwdExMemWrites: assert property (@(posedge clk) disable iff (!rstN)
		(idExCtrl != '0 && (fwdA == cpuPkg::fwdExMem || fwdB == cpuPkg::fwdExMem))
		|-> (exMemFwd.ctrl.regWrite && !exMemFwd.ctrl.memRead))
		else $error("EX/MEM forward from a load or from a stage without regWrite");

endmodule

// ==== verilog/memoryStage.sv ====
// memory access: word-addressed data memory, MEM/WB register and writeback select
// the ALU result is used directly as the word index
module memoryStage #(
	parameter int dmemWords = 64
) (
	input logic clk,
	input logic rstN,
	exMemBus.consumer exMem,
	wbBus.source wb,
	output logic storeValid,
	output logic [cpuPkg::dataWidth-1:0] storeAddr,
	output logic [cpuPkg::dataWidth-1:0] storeData
);

	localparam int dmemAddrWidth = $clog2(dmemWords);

	logic [cpuPkg::dataWidth-1:0] dmem [dmemWords];
	logic [dmemAddrWidth-1:0] wordAddr;
	logic [cpuPkg::dataWidth-1:0] loadData;
	logic memWbWrite;
	logic memWbToReg;
	logic [cpuPkg::regAddrWidth-1:0] memWbReg;
	logic [cpuPkg::dataWidth-1:0] memWbLoad;
	logic [cpuPkg::dataWidth-1:0] memWbAlu;

	assign wordAddr = exMem.aluResult[dmemAddrWidth-1:0];

	// synchronous store, combinational load
	always_ff @(posedge clk) begin
		if (exMem.ctrl.memWrite) begin
			dmem[wordAddr] <= exMem.storeData;
		end
	end
	assign loadData = dmem[wordAddr];

	// observation of the write strobe, one cycle per sw
	assign storeValid = exMem.ctrl.memWrite;
	assign storeAddr = exMem.aluResult;
	assign storeData = exMem.storeData;

	// MEM/WB, writes to r0 are dropped here
	always_ff @(posedge clk) begin
		if (!rstN) begin
			memWbWrite <= 1'b0;
			memWbToReg <= 1'b0;
		end else begin
			memWbWrite <= exMem.ctrl.regWrite && exMem.destReg != '0;
			memWbToReg <= exMem.ctrl.memToReg;
		end
		memWbReg <= exMem.destReg;
		memWbLoad <= loadData;
		memWbAlu <= exMem.aluResult;
	end

	assign wb.wbWrite = memWbWrite;
	assign wb.wbReg = memWbReg;
	assign wb.wbData = memWbToReg ? memWbLoad : memWbAlu;

	// main control in decode never marks one instruction as both load and store
	noLoadAndStore: assert property (@(posedge clk) disable iff (!rstN)
		!(exMem.ctrl.memRead && exMem.ctrl.memWrite))
		else $error("memRead and memWrite both set in EX/MEM");

endmodule

// ==== verilog/cpuTop.sv ====
// top level of the five-stage core: wires the stages together and brings out
// the program load port plus writeback and store events for checking
module cpuTop #(
	parameter int imemWords = 64,
	parameter int dmemWords = 64
) (
	input logic clk,
	input logic rstN,
	input logic progWrite,
	input logic [$clog2(imemWords)-1:0] progAddr,
	input logic [cpuPkg::dataWidth-1:0] progData,
	output logic wbValid,
	output logic [cpuPkg::regAddrWidth-1:0] wbReg,
	output logic [cpuPkg::dataWidth-1:0] wbData,
	output logic storeValid,
	output logic [cpuPkg::dataWidth-1:0] storeAddr,
	output logic [cpuPkg::dataWidth-1:0] storeData
);

	logic stall;
	logic [cpuPkg::dataWidth-1:0] ifIdInstr;
	cpuPkg::ctrlT idExCtrl;
	logic [cpuPkg::dataWidth-1:0] idExRs1Data;
	logic [cpuPkg::dataWidth-1:0] idExRs2Data;
	logic [cpuPkg::dataWidth-1:0] idExImm;
	logic [cpuPkg::regAddrWidth-1:0] idExRs;
	logic [cpuPkg::regAddrWidth-1:0] idExRt;
	logic [cpuPkg::regAddrWidth-1:0] idExRd;
	cpuPkg::functT idExFunct;

	exMemBus exMem ();
	wbBus wb ();

	fetchStage #(.imemWords(imemWords)) u_fetchStage (
		.clk, .rstN, .stall, .progWrite, .progAddr, .progData, .ifIdInstr
	);

	decodeStage u_decodeStage (
		.clk, .rstN, .ifIdInstr, .wb(wb.regWriter), .stall,
		.idExCtrl, .idExRs1Data, .idExRs2Data, .idExImm,
		.idExRs, .idExRt, .idExRd, .idExFunct
	);

	// EX/MEM is driven and forwarded from the same bus instance
	executeStage u_executeStage (
		.clk, .rstN, .idExCtrl, .idExRs1Data, .idExRs2Data, .idExImm,
		.idExRs, .idExRt, .idExRd, .idExFunct,
		.exMem(exMem.producer), .exMemFwd(exMem.forwardSrc), .wb(wb.forwardSrc)
	);

	memoryStage #(.dmemWords(dmemWords)) u_memoryStage (
		.clk, .rstN, .exMem(exMem.consumer), .wb(wb.source),
		.storeValid, .storeAddr, .storeData
	);

	// writeback event, one pulse per retiring non-r0 write
	assign wbValid = wb.wbWrite;
	assign wbReg = wb.wbReg;
	assign wbData = wb.wbData;

endmodule

// ==== sim/cpuChecker.sv ====
// watches the writeback and store events of the core and compares them in program order
// the testbench queues the expected events of each test through the tasks below
module cpuChecker (
	input logic clk,
	input logic rstN,
	input logic wbValid,
	input logic [cpuPkg::regAddrWidth-1:0] wbReg,
	input logic [cpuPkg::dataWidth-1:0] wbData,
	input logic storeValid,
	input logic [cpuPkg::dataWidth-1:0] storeAddr,
	input logic [cpuPkg::dataWidth-1:0] storeData
);

	// one program-order queue per event kind, a wb and a store may share a cycle
	logic [cpuPkg::regAddrWidth-1:0] expReg[$];
	logic [cpuPkg::dataWidth-1:0] expWbData[$];
	logic [cpuPkg::dataWidth-1:0] expAddr[$];
	logic [cpuPkg::dataWidth-1:0] expStData[$];
	string testName;
	bit active;
	int idleCycles;
	int testErrors;
	int eventsSeen;
	int passedCount = 0;
	int failedCount = 0;

	task automatic startTest(input string name);
		testName = name;
		active = 1'b1;
		idleCycles = 0;
		testErrors = 0;
		eventsSeen = 0;
	endtask

	task automatic expectWrite(input logic [cpuPkg::regAddrWidth-1:0] r,
		input logic [cpuPkg::dataWidth-1:0] v);
		expReg.push_back(r);
		expWbData.push_back(v);
	endtask

	task automatic expectStore(input logic [cpuPkg::dataWidth-1:0] a,
		input logic [cpuPkg::dataWidth-1:0] v);
		expAddr.push_back(a);
		expStData.push_back(v);
	endtask

	function automatic int pendingEvents();
		return expReg.size() + expAddr.size();
	endfunction

	function automatic int failedTests();
		return failedCount;
	endfunction

	// leftovers are events the core never produced
	task automatic finishTest();
		foreach (expReg[i]) begin
			$display("test %s: writeback of %h to r%0d never happened", testName, expWbData[i],
				expReg[i]);
		end
		foreach (expAddr[i]) begin
			$display("test %s: store of %h to address %h never happened", testName,
				expStData[i], expAddr[i]);
		end
		testErrors += expReg.size() + expAddr.size();
		expReg.delete();
		expWbData.delete();
		expAddr.delete();
		expStData.delete();
		active = 1'b0;
		if (testErrors == 0) begin
			passedCount++;
			$display("test %s: ok, %0d events", testName, eventsSeen);
		end else begin
			failedCount++;
			$display("test %s: FAILED with %0d errors", testName, testErrors);
		end
	endtask

	task automatic reportCounts();
		$display("%0d tests run, %0d ok, %0d with errors", passedCount + failedCount,
			passedCount, failedCount);
	endtask

	// sample mid-cycle, all observed outputs settle after the rising edge
	always @(negedge clk) begin
		if (rstN && active) begin
			idleCycles++;
			if (wbValid) begin
				idleCycles = 0;
				eventsSeen++;
				if (expReg.size() == 0) begin
					$display("unexpected writeback of %h to r%0d at time %0t", wbData, wbReg, $time);
					testErrors++;
				end else begin
					if (wbReg !== expReg[0] || wbData !== expWbData[0]) begin
						$display("mismatch at time %0t: writeback r%0d=%h, expected r%0d=%h",
							$time, wbReg, wbData, expReg[0], expWbData[0]);
						testErrors++;
					end
					expReg.delete(0);
					expWbData.delete(0);
				end
			end
			if (storeValid) begin
				idleCycles = 0;
				eventsSeen++;
				if (expAddr.size() == 0) begin
					$display("unexpected store of %h to address %h at time %0t", storeData,
						storeAddr, $time);
					testErrors++;
				end else begin
					if (storeAddr !== expAddr[0] || storeData !== expStData[0]) begin
						$display("mismatch at time %0t: store [%h]=%h, expected [%h]=%h",
							$time, storeAddr, storeData, expAddr[0], expStData[0]);
						testErrors++;
					end
					expAddr.delete(0);
					expStData.delete(0);
				end
			end
		end
	end

endmodule

// ==== sim/cpuTb.sv ====
// testbench top for the pipelined core: reads programs and expected events from the
// stimulus file, loads each program under reset and lets cpuChecker judge the results
module cpuTb;

	localparam int imemWords = 64;
	localparam int dmemWords = 64;
	localparam int addrWidth = $clog2(imemWords);
	// cycles without any event before a test gives up waiting
	localparam int idleLimit = 40;
	// extra cycles after the last expected event, to catch stray writebacks
	localparam int drainCycles = 6;

	logic clk;
	logic rstN;
	logic progWrite;
	logic [addrWidth-1:0] progAddr;
	logic [cpuPkg::dataWidth-1:0] progData;
	logic wbValid;
	logic [cpuPkg::regAddrWidth-1:0] wbReg;
	logic [cpuPkg::dataWidth-1:0] wbData;
	logic storeValid;
	logic [cpuPkg::dataWidth-1:0] storeAddr;
	logic [cpuPkg::dataWidth-1:0] storeData;

	// parsed stimulus, each test owns a slice starting at instrFirst and eventFirst
	string testNames[$];
	int instrFirst[$];
	int eventFirst[$];
	logic [cpuPkg::dataWidth-1:0] instrWords[$];
	byte eventKind[$];
	logic [cpuPkg::dataWidth-1:0] eventKey[$];
	logic [cpuPkg::dataWidth-1:0] eventValue[$];
	int parseErrors;
	int limitCycles;

	cpuTop #(.imemWords(imemWords), .dmemWords(dmemWords)) u_cpuTop (
		.clk, .rstN, .progWrite, .progAddr, .progData,
		.wbValid, .wbReg, .wbData, .storeValid, .storeAddr, .storeData
	);

	cpuChecker u_checker (
		.clk, .rstN, .wbValid, .wbReg, .wbData, .storeValid, .storeAddr, .storeData
	);

	// period 8
	always #4 clk = ~clk;

	// token based reader, '#' starts a comment that runs to the end of the line
	task automatic readStimulus(output bit fileOk);
		int fd;
		string tok;
		string rest;
		logic [cpuPkg::dataWidth-1:0] key;
		logic [cpuPkg::dataWidth-1:0] value;
		fd = $fopen("sim/programStimulus.txt", "r");
		fileOk = (fd != 0);
		if (fileOk) begin
			while ($fscanf(fd, "%s", tok) == 1) begin
				if (tok.len() > 0 && tok[0] == "#") begin
					void'($fgets(rest, fd));
				end else if (tok == "T") begin
					void'($fscanf(fd, "%s", tok));
					testNames.push_back(tok);
					instrFirst.push_back(instrWords.size());
					eventFirst.push_back(eventKind.size());
				end else if (tok == "I") begin
					void'($fscanf(fd, "%h", value));
					instrWords.push_back(value);
				end else if (tok == "W" || tok == "S") begin
					// register number in decimal, store address in hex
					if (tok == "W") begin
						void'($fscanf(fd, "%d %h", key, value));
					end else begin
						void'($fscanf(fd, "%h %h", key, value));
					end
					eventKind.push_back(tok[0]);
					eventKey.push_back(key);
					eventValue.push_back(value);
				end else begin
					$display("unknown record '%s' in the stimulus file", tok);
					parseErrors++;
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic runTest(input int t);
		int first;
		int count;
		int evEnd;
		first = instrFirst[t];
		count = (t + 1 < testNames.size()) ? instrFirst[t + 1] - first : instrWords.size() - first;
		evEnd = (t + 1 < testNames.size()) ? eventFirst[t + 1] : eventKind.size();
		// core held in reset while the whole memory is rewritten, old words turn into nops
		@(posedge clk);
		#1;
		rstN = 1'b0;
		for (int i = 0; i < imemWords; i++) begin
			progWrite = 1'b1;
			progAddr = addrWidth'(i);
			progData = (i < count) ? instrWords[first + i] : '0;
			@(posedge clk);
			#1;
		end
		progWrite = 1'b0;
		u_checker.startTest(testNames[t]);
		for (int k = eventFirst[t]; k < evEnd; k++) begin
			if (eventKind[k] == "W") begin
				u_checker.expectWrite(eventKey[k][cpuPkg::regAddrWidth-1:0], eventValue[k]);
			end else begin
				u_checker.expectStore(eventKey[k], eventValue[k]);
			end
		end
		@(posedge clk);
		#1;
		rstN = 1'b1;
		// done once every expected event arrived, or when the core goes quiet
		while (u_checker.pendingEvents() > 0 && u_checker.idleCycles < idleLimit) begin
			@(posedge clk);
		end
		repeat (drainCycles) @(posedge clk);
		u_checker.finishTest();
	endtask

	initial begin
		bit fileOk;
		clk = 1'b0;
		rstN = 1'b0;
		progWrite = 1'b0;
		progAddr = '0;
		progData = '0;
		parseErrors = 0;
		limitCycles = 0;
		readStimulus(fileOk);
		if (!fileOk || parseErrors != 0 || testNames.size() == 0) begin
			$display("could not read the test programs from sim/programStimulus.txt");
			$display("tests failed");
		end else begin
			// 12 per word, 60 per test, plus the memory rewrite done under reset
			limitCycles = 12 * instrWords.size() + (60 + imemWords + 1) * testNames.size();
			for (int t = 0; t < testNames.size(); t++) begin
				runTest(t);
			end
			u_checker.reportCounts();
			if (u_checker.failedTests() == 0) begin
				$display("all tests passed");
			end else begin
				$display("tests failed");
			end
		end
		$finish;
	end

	// watchdog, armed once the stimulus is known
	initial begin
		wait (limitCycles > 0);
		repeat (limitCycles) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run did not complete", limitCycles);
		$display("tests failed");
		$finish;
	end

endmodule

// ==== sim/programStimulus.txt ====
# records: T name | I instruction word (hex) | W register (decimal) value (hex)
# | S address value (hex); W and S follow the instruction that produces them
T alu_basic
I 20010005  W 1 00000005
I 20020003  W 2 00000003
I 00000000  I 00000000  I 00000000
I 00221820  W 3 00000008
I 00222022  W 4 00000002
I 00222824  W 5 00000001
I 00223025  W 6 00000007
I 0041382a  W 7 00000001
I 0022402a  W 8 00000000
T fwd_exmem
I 2001000a  W 1 0000000a
I 00211020  W 2 00000014
I 00411822  W 3 0000000a
I 00622025  W 4 0000001e
T fwd_distance
I 20010007  W 1 00000007
I 20020001  W 2 00000001
I 00221820  W 3 00000008
I 20040064  W 4 00000064
I 00000000  I 00000000
I 00832820  W 5 0000006c
T store_load
I 20011234  W 1 00001234
I 20020005  W 2 00000005
I ac410003  S 00000008 00001234
I 00000000
I 8c030008  W 3 00001234
T load_use
I 20010055  W 1 00000055
I ac010002  S 00000002 00000055
I 8c020002  W 2 00000055
I 00411820  W 3 000000aa
I 20040001  W 4 00000001
T reg_zero
I 20000009
I 20010004  W 1 00000004
I 00210020
I 00201020  W 2 00000004
I 00011820  W 3 00000004

// ==== files.f ====
verilog/cpuPkg.sv
verilog/pipeBus.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memoryStage.sv
verilog/cpuTop.sv
sim/cpuChecker.sv
sim/cpuTb.sv

// ==== Makefile ====
# Verilator build and run for the pipelined core, run from the project root
TOP := cpuTb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f files.f

obj_dir/V$(TOP): files.f $(wildcard verilog/*.sv sim/*.sv)
	verilator --binary --timing --assert --top-module $(TOP) -f files.f

# the status of grep decides pass or fail
sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
